// ==== source/ddrPkg.sv ====
/*
 * DDR3 channel widths, word types and command encoding
 */
package ddrPkg;

	// ----------------------------------------------------------
	// Channel geometry
	// ----------------------------------------------------------

	// Controller address, counted in DDR words
	localparam int DdrAddrWidth = 28;
	// One full DDR burst word
	localparam int DdrDataWidth = 512;

	typedef logic [DdrAddrWidth-1:0] ddrAddrT;
	typedef logic [DdrDataWidth-1:0] ddrDataT;

	// ----------------------------------------------------------
	// Commands
	// ----------------------------------------------------------

	// Encoding as the controller app port expects it
	typedef enum logic [2:0] {
		cmdWrite = 3'b000,
		cmdRead  = 3'b001
	} ddrCmdT;

endpackage

// ==== source/oramPkg.sv ====
/*
 * ORAM bucket geometry and header field widths
 * Bucket header word with raw and field views
 */
package oramPkg;
	import ddrPkg::*;

	// ----------------------------------------------------------
	// Bucket geometry
	// ----------------------------------------------------------

	// Each IV field of the header
	localparam int IvWidth = 64;
	// One valid bit per block slot in a bucket
	localparam int ValidBitsWidth = 4;
	// Unused bits above the header fields
	localparam int HeaderPadWidth = DdrDataWidth - 2 * IvWidth - ValidBitsWidth;

	typedef logic [IvWidth-1:0] ivT;
	typedef logic [ValidBitsWidth-1:0] validBitsT;

	// Header layout, MSB first
	typedef struct packed {
		logic [HeaderPadWidth-1:0] padding;
		ivT ivLow;
		validBitsT validBits;
		ivT ivHigh;
	} bucketHeaderFieldsT;

	// Same DDR word seen by the DRAM side or by the ORAM logic
	typedef union packed {
		ddrDataT raw;
		bucketHeaderFieldsT fields;
	} bucketHeaderT;

endpackage

// ==== source/ddrCmdIf.sv ====
/*
 * DDR3 command and write-data channels, with source and sink modports
 */
`timescale 1ns/100ps

interface ddrCmdIf
	import ddrPkg::*;
();

	// Command channel
	ddrAddrT cmdAddr;
	ddrCmdT cmd;
	logic cmdValid;
	logic cmdReady;

	// Write-data channel, independent of commands
	ddrDataT wrData;
	logic wrValid;
	logic wrReady;

	// Initializer side
	modport source (
		output cmdAddr, cmd, cmdValid,
		output wrData, wrValid,
		input cmdReady, wrReady
	);

	// Memory controller side
	modport sink (
		input cmdAddr, cmd, cmdValid,
		input wrData, wrValid,
		output cmdReady, wrReady
	);

endinterface

// ==== source/strideCounter.sv ====
/*
 * Up counter with clear and fixed step size
 */
`timescale 1ns/100ps

module strideCounter #(
	parameter int Width = 8,
	parameter int Factor = 1
) (
	input logic Clock,
	input logic arstN,
	input logic Clear,
	input logic Enable,
	output logic [Width-1:0] Count
);

	// Step sized to the counter
	localparam logic [Width-1:0] Step = Width'(Factor);

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			Count <= '0;
		end else if (Clear) begin
			// Clear wins over Enable
			Count <= '0;
		end else if (Enable) begin
			Count <= Count + Step;
		end
	end

endmodule

// ==== source/bucketInitializer.sv ====
/*
 * Bucket initializer, one write command and BktSizeDdrWords data words
 * per ORAM bucket, header word first, then Done
 */
`timescale 1ns/100ps

module bucketInitializer
	import ddrPkg::*;
	import oramPkg::*;
#(
	parameter int NumBuckets = 15,
	parameter int BktSizeDdrWords = 4,
	parameter ddrAddrT BaseAddr = '0
) (
	input logic Clock,
	input logic arstN,
	ddrCmdIf.source ddr,
	output logic Done
);

	// ----------------------------------------------------------
	// Constants
	// ----------------------------------------------------------

	// Words over the whole tree
	localparam int TotalWords = NumBuckets * BktSizeDdrWords;
	localparam int WordCntWidth = $clog2(TotalWords + 1);
	// Command counter counts in address units
	localparam ddrAddrT CmdEnd = DdrAddrWidth'(TotalWords);
	localparam logic [WordCntWidth-1:0] WordEnd = WordCntWidth'(TotalWords);
	localparam logic [WordCntWidth-1:0] BktWords = WordCntWidth'(BktSizeDdrWords);

	// ----------------------------------------------------------
	// Signals
	// ----------------------------------------------------------

	logic armed;
	logic cmdFinished;
	logic wrFinished;
	logic cmdFire;
	logic wrFire;
	ddrAddrT cmdCount;
	logic [WordCntWidth-1:0] wrCount;
	logic [WordCntWidth-1:0] bucketIdx;
	logic [WordCntWidth-1:0] wordOffset;
	bucketHeaderT wrWord;

	// ----------------------------------------------------------
	// Start-up
	// ----------------------------------------------------------

	// Goes high on the first edge after reset release
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Counters
	// ----------------------------------------------------------

	// Bucket address offset, one bucket per command
	strideCounter #(
		.Width(DdrAddrWidth),
		.Factor(BktSizeDdrWords)
	) cmdCnt (
		.Clock(Clock),
		.arstN(arstN),
		.Clear(~armed),
		.Enable(cmdFire),
		.Count(cmdCount)
	);

	// Data word index over the whole tree
	strideCounter #(
		.Width(WordCntWidth),
		.Factor(1)
	) wrCnt (
		.Clock(Clock),
		.arstN(arstN),
		.Clear(~armed),
		.Enable(wrFire),
		.Count(wrCount)
	);

	// Each channel ends on the edge of its last transfer
	assign cmdFinished = (cmdCount == CmdEnd);
	assign wrFinished = (wrCount == WordEnd);

	// Handshakes
	assign cmdFire = ddr.cmdValid & ddr.cmdReady;
	assign wrFire = ddr.wrValid & ddr.wrReady;

	// ----------------------------------------------------------
	// Command channel
	// ----------------------------------------------------------

	assign ddr.cmdValid = armed & ~cmdFinished;
	assign ddr.cmdAddr = BaseAddr + cmdCount;
	// Initialization only ever writes
	assign ddr.cmd = cmdWrite;

	// ----------------------------------------------------------
	// Write-data channel
	// ----------------------------------------------------------

	// Position of the current word in the tree
	assign bucketIdx = wrCount / BktWords;
	assign wordOffset = wrCount % BktWords;

	// Header on the first word of a bucket, zeros otherwise
	always_comb begin
		wrWord.raw = '0;
		if (wordOffset == '0) begin
			// All blocks invalid
			wrWord.fields.validBits = '0;
			// Bucket index stands in for IV entropy
			wrWord.fields.ivLow = IvWidth'(bucketIdx);
			wrWord.fields.ivHigh = IvWidth'(bucketIdx);
		end
	end

	assign ddr.wrValid = armed & ~wrFinished;
	assign ddr.wrData = wrWord.raw;

	// ----------------------------------------------------------
	// Completion
	// ----------------------------------------------------------

	// Sticky until reset
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			Done <= 1'b0;
		end else if (cmdFinished && wrFinished) begin
			Done <= 1'b1;
		end
	end

endmodule

// ==== source/ramInitTop.sv ====
/*
 * DRAM initialization top level, initializer and DDR3 channel ports
 */
`timescale 1ns/100ps

module ramInitTop
	import ddrPkg::*;
#(
	parameter int NumBuckets = 15,
	parameter int BktSizeDdrWords = 4,
	parameter ddrAddrT BaseAddr = '0
) (
	input logic Clock,
	input logic arstN,

	// Command channel to the DDR3 controller
	output ddrAddrT dramCommandAddress,
	output ddrCmdT dramCommand,
	output logic dramCommandValid,
	input logic dramCommandReady,

	// Write-data channel to the DDR3 controller
	output ddrDataT dramWriteData,
	output logic dramWriteDataValid,
	input logic dramWriteDataReady,

	// Tree fully written
	output logic Done
);

	// ----------------------------------------------------------
	// Channel bundle
	// ----------------------------------------------------------

	ddrCmdIf ddr ();

	// ----------------------------------------------------------
	// Initializer
	// ----------------------------------------------------------

	bucketInitializer #(
		.NumBuckets(NumBuckets),
		.BktSizeDdrWords(BktSizeDdrWords),
		.BaseAddr(BaseAddr)
	) init (
		.Clock(Clock),
		.arstN(arstN),
		.ddr(ddr.source),
		.Done(Done)
	);

	// ----------------------------------------------------------
	// Sink side onto the plain ports
	// ----------------------------------------------------------

	assign dramCommandAddress = ddr.cmdAddr;
	assign dramCommand = ddr.cmd;
	assign dramCommandValid = ddr.cmdValid;
	assign ddr.cmdReady = dramCommandReady;

	assign dramWriteData = ddr.wrData;
	assign dramWriteDataValid = ddr.wrValid;
	assign ddr.wrReady = dramWriteDataReady;

endmodule

// ==== testbench/ramInitTb.sv ====
/*
 * Testbench for ramInitTop with a back-pressure table and a reference stream model
 */
`timescale 1ns/100ps

module ramInitTb
	import ddrPkg::*;
	import oramPkg::*;
();

	// ----------------------------------------------------------
	// Setup
	// ----------------------------------------------------------

	localparam int NumBuckets = 15;
	localparam int BktSizeDdrWords = 4;
	localparam ddrAddrT BaseAddr = '0;
	localparam int TotalWords = NumBuckets * BktSizeDdrWords;
	localparam int ResetCycles = 5;
	// Quiet cycles watched after Done
	localparam int TailCycles = 8;

	// Ready percentages per row for command and data
	localparam int NumRows = 5;
	localparam int CmdPct [NumRows] = '{100, 100, 30, 50, 10};
	localparam int WrPct [NumRows] = '{100, 30, 100, 50, 10};

	logic Clock;
	logic arstN;
	ddrAddrT dramCommandAddress;
	ddrCmdT dramCommand;
	logic dramCommandValid;
	logic dramCommandReady;
	ddrDataT dramWriteData;
	logic dramWriteDataValid;
	logic dramWriteDataReady;
	logic Done;

	// Monitor state
	int cmdSeen;
	int wrSeen;
	logic doneDue;
	logic released;
	logic endedBefore;
	int cycleCount = 0;

	ramInitTop #(
		.NumBuckets(NumBuckets),
		.BktSizeDdrWords(BktSizeDdrWords),
		.BaseAddr(BaseAddr)
	) dut (
		.Clock(Clock),
		.arstN(arstN),
		.dramCommandAddress(dramCommandAddress),
		.dramCommand(dramCommand),
		.dramCommandValid(dramCommandValid),
		.dramCommandReady(dramCommandReady),
		.dramWriteData(dramWriteData),
		.dramWriteDataValid(dramWriteDataValid),
		.dramWriteDataReady(dramWriteDataReady),
		.Done(Done)
	);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------

	// One bucket stride per command
	function automatic ddrAddrT expectedAddr(int k);
		return ddrAddrT'(BaseAddr + k * BktSizeDdrWords);
	endfunction

	function automatic ddrDataT expectedWord(int j);
		ddrDataT word;
		ddrDataT idx;
		word = '0;
		if (j % BktSizeDdrWords == 0) begin
			idx = DdrDataWidth'(j / BktSizeDdrWords);
			// ivLow above the valid bits and ivHigh at the bottom
			word = (idx << (IvWidth + ValidBitsWidth)) | idx;
		end
		return word;
	endfunction

	function automatic logic readyDraw(int pct);
		return ($urandom_range(99) < pct);
	endfunction

	// Worst case per row at the slowest ready rate times two
	function automatic int cycleLimit();
		int total;
		int minPct;
		int r;
		total = 0;
		for (r = 0; r < NumRows; r++) begin
			minPct = (CmdPct[r] < WrPct[r]) ? CmdPct[r] : WrPct[r];
			total += NumBuckets * (BktSizeDdrWords + 1) * 100 / minPct * 2;
			total += ResetCycles + TailCycles + 2;
		end
		return total;
	endfunction

	// ----------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------

	task automatic addrCompare(input string name, input ddrAddrT got, input ddrAddrT exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic cmdCompare(input string name, input ddrCmdT got, input ddrCmdT exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Both words decoded through the header view
	task automatic dataCompare(input string name, input ddrDataT got, input ddrDataT exp);
		bucketHeaderT gotHdr;
		bucketHeaderT expHdr;
		gotHdr.raw = got;
		expHdr.raw = exp;
		if (gotHdr.raw !== expHdr.raw) begin
			$display("Error at %0t: %s is pad %h ivLow %h valid %h ivHigh %h, %s%h %s%h %s%h %s%h",
				$time, name, gotHdr.fields.padding, gotHdr.fields.ivLow,
				gotHdr.fields.validBits, gotHdr.fields.ivHigh,
				"expected pad ", expHdr.fields.padding, "ivLow ", expHdr.fields.ivLow,
				"valid ", expHdr.fields.validBits, "ivHigh ", expHdr.fields.ivHigh);
			$display("test failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic flagCompare(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// ----------------------------------------------------------
	// Monitor sampling mid-cycle
	// ----------------------------------------------------------

	always @(negedge Clock) begin
		if (!arstN) begin
			flagCompare("dramCommandValid", dramCommandValid, 1'b0);
			flagCompare("dramWriteDataValid", dramWriteDataValid, 1'b0);
			flagCompare("Done", Done, 1'b0);
			cmdSeen = 0;
			wrSeen = 0;
			doneDue = 1'b0;
			released = 1'b0;
		end else if (!released) begin
			// First edge after release, still quiet
			flagCompare("dramCommandValid", dramCommandValid, 1'b0);
			flagCompare("dramWriteDataValid", dramWriteDataValid, 1'b0);
			flagCompare("Done", Done, 1'b0);
			released = 1'b1;
		end else begin
			endedBefore = (cmdSeen == NumBuckets) && (wrSeen == TotalWords);
			flagCompare("Done", Done, doneDue);
			flagCompare("dramCommandValid", dramCommandValid, cmdSeen < NumBuckets);
			flagCompare("dramWriteDataValid", dramWriteDataValid, wrSeen < TotalWords);
			// Payload checked on every valid cycle so stalls must hold it
			if (dramCommandValid) begin
				addrCompare("dramCommandAddress", dramCommandAddress, expectedAddr(cmdSeen));
				cmdCompare("dramCommand", dramCommand, cmdWrite);
				if (dramCommandReady) cmdSeen++;
			end
			if (dramWriteDataValid) begin
				dataCompare("dramWriteData", dramWriteData, expectedWord(wrSeen));
				if (dramWriteDataReady) wrSeen++;
			end
			// Done follows one cycle after both channels end
			doneDue = doneDue | endedBefore;
		end
	end

	// Run limit
	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit()) begin
			$display("Timeout: the run took more than %0d cycles", cycleLimit());
			$display("test failed");
			$fatal(1, "Timeout");
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------

	initial begin
		int row;
		arstN = 1'b0;
		dramCommandReady = 1'b0;
		dramWriteDataReady = 1'b0;
		void'($urandom(14));
		for (row = 0; row < NumRows; row++) begin
			@(posedge Clock);
			arstN <= 1'b0;
			dramCommandReady <= 1'b0;
			dramWriteDataReady <= 1'b0;
			repeat (ResetCycles) @(posedge Clock);
			arstN <= 1'b1;
			dramCommandReady <= readyDraw(CmdPct[row]);
			dramWriteDataReady <= readyDraw(WrPct[row]);
			@(negedge Clock);
			while (!Done) begin
				@(posedge Clock);
				dramCommandReady <= readyDraw(CmdPct[row]);
				dramWriteDataReady <= readyDraw(WrPct[row]);
				@(negedge Clock);
			end
			// Done must hold with no traffic
			repeat (TailCycles) begin
				@(posedge Clock);
				dramCommandReady <= readyDraw(CmdPct[row]);
				dramWriteDataReady <= readyDraw(WrPct[row]);
			end
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== build.f ====
source/ddrPkg.sv
source/oramPkg.sv
source/ddrCmdIf.sv
source/strideCounter.sv
source/bucketInitializer.sv
source/ramInitTop.sv
testbench/ramInitTb.sv

// ==== Makefile ====
# Verilator build for the DRAM initialization path

VERILATOR  ?= verilator
FILELIST   := build.f
TB_TOP     := ramInitTb
RTL_TOP    := ramInitTop
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing

.PHONY: all lint sim clean

all: sim

# Static checks on the design top level
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run, exit status follows the testbench result
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
